// File: common/ad7124_consts.svh
`ifndef AD7124_CONSTS_SVH
`define AD7124_CONSTS_SVH

// ------------------------------------------------------------
// SPI clocking
// ------------------------------------------------------------

// sclk half period lasts (div + 1) spi_clk cycles
`define AD7124_CLK_DIV 24

// mosi level between bytes
`define AD7124_SDO_IDLE 1'b1

// ------------------------------------------------------------
// conversion read sequence
// ------------------------------------------------------------

// comms register write, read of the data register
`define AD7124_RD_DATA_CMD 8'h42

// data bytes clocked in after the command byte
`define AD7124_DATA_BYTES 3

// ------------------------------------------------------------
// sample buffer
// ------------------------------------------------------------

// must stay a power of two, pointers wrap by overflow
`define AD7124_FIFO_DEPTH 8

`endif

// File: common/ad7124_pkg.sv
`default_nettype none

package ad7124_pkg;

    // ------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------

    // one byte on the spi wire
    typedef logic [7:0] spi_byte_t;

    // one conversion result, msb first on the wire
    typedef logic [23:0] sample_t;

    // byte position in a read sequence
    typedef logic [1:0] byte_cnt_t;

    // ------------------------------------------------------------
    // sequencer states
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        SEND = 2'd1,
        PUSH = 2'd2
    } seq_state_t;

endpackage

`default_nettype wire

// File: common/spi_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_xfer_if;

    import ad7124_pkg::*;

    // byte request toward the engine
    logic      xfer_valid;
    logic      xfer_ready;
    spi_byte_t tx_byte;

    // byte received while tx_byte was shifted out
    logic      rx_valid;
    spi_byte_t rx_byte;

    modport seq (
        output xfer_valid,
        output tx_byte,
        input  xfer_ready,
        input  rx_valid,
        input  rx_byte
    );

    modport engine (
        input  xfer_valid,
        input  tx_byte,
        output xfer_ready,
        output rx_valid,
        output rx_byte
    );

endinterface

`default_nettype wire

// File: verilog/drdy_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module drdy_trigger (
    input  wire logic spi_clk_i,
    input  wire logic rst_n_i,
    input  wire logic miso_i,
    input  wire logic seq_active_i,
    output logic      trigger_o
);

    // two flop synchronizer plus one history stage
    logic miso_s1;
    logic miso_s2;
    logic miso_s3;
    logic fall_edge;
    logic trigger_q;

    always_ff @(posedge spi_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // dout/rdy idles high
            miso_s1 <= 1'b1;
            miso_s2 <= 1'b1;
            miso_s3 <= 1'b1;
        end else begin
            miso_s1 <= miso_i;
            miso_s2 <= miso_s1;
            miso_s3 <= miso_s2;
        end
    end

    // data bits during a read must not look like a new conversion
    assign fall_edge = miso_s3 && !miso_s2 && !seq_active_i;

    always_ff @(posedge spi_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= fall_edge;
        end
    end

    assign trigger_o = trigger_q;

    a_trigger_single : assert property (
        @(posedge spi_clk_i) disable iff (!rst_n_i)
        trigger_o |=> !trigger_o
    );

endmodule

`default_nettype wire

// File: verilog/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ad7124_consts.svh"

module conv_sequencer (
    input  wire logic           spi_clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           trigger_i,
    output logic                seq_active_o,
    spi_xfer_if.seq             xfer,
    output logic                push_valid_o,
    input  wire logic           push_ready_i,
    output ad7124_pkg::sample_t push_data_o
);

    import ad7124_pkg::*;

    localparam byte_cnt_t LAST_BYTE = byte_cnt_t'(`AD7124_DATA_BYTES);

    seq_state_t state;
    // 0 is the command byte, 1..3 carry data
    byte_cnt_t  byte_cnt;
    logic       xfer_valid_q;
    sample_t    sample_q;

    // ------------------------------------------------------------
    // read sequence FSM
    // ------------------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= IDLE;
            byte_cnt     <= '0;
            xfer_valid_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (trigger_i) begin
                        state        <= SEND;
                        byte_cnt     <= '0;
                        xfer_valid_q <= 1'b1;
                    end
                end
                SEND: begin
                    if (xfer_valid_q && xfer.xfer_ready) begin
                        xfer_valid_q <= 1'b0;
                    end
                    if (xfer.rx_valid) begin
                        if (byte_cnt == LAST_BYTE) begin
                            state <= PUSH;
                        end else begin
                            byte_cnt     <= byte_cnt + 2'd1;
                            xfer_valid_q <= 1'b1;
                        end
                    end
                end
                PUSH: begin
                    // sample waits here while the fifo is full
                    if (push_ready_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // data bytes arrive msb first
    always_ff @(posedge spi_clk_i) begin
        if (state == SEND && xfer.rx_valid && byte_cnt != '0) begin
            sample_q <= {sample_q[15:0], xfer.rx_byte};
        end
    end

    // byte_cnt only moves on rx_valid, so tx_byte holds until accepted
    assign xfer.xfer_valid = xfer_valid_q;
    assign xfer.tx_byte    = (byte_cnt == '0) ? spi_byte_t'(`AD7124_RD_DATA_CMD) : '0;

    assign seq_active_o = (state != IDLE);
    assign push_valid_o = (state == PUSH);
    assign push_data_o  = sample_q;

    a_push_hold : assert property (
        @(posedge spi_clk_i) disable iff (!rst_n_i)
        push_valid_o && !push_ready_i |=> push_valid_o && $stable(push_data_o)
    );

endmodule

`default_nettype wire

// File: spi_exec/spi_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "ad7124_consts.svh"

module spi_byte_engine (
    input  wire logic spi_clk_i,
    input  wire logic rst_n_i,
    spi_xfer_if.engine xfer,
    output logic      sclk_o,
    output logic      mosi_o,
    input  wire logic miso_i
);

    import ad7124_pkg::*;

    localparam logic [4:0] DIV_LAST = 5'(`AD7124_CLK_DIV);

    logic       busy;
    logic [4:0] div_cnt;
    // 16 half periods per byte, even = sclk low
    logic [3:0] half_cnt;
    logic       half_done;
    logic       accept;
    logic       sclk_q;
    logic       mosi_q;
    logic       rx_valid_q;
    spi_byte_t  tx_sh;
    spi_byte_t  rx_sh;

    assign accept    = xfer.xfer_valid && !busy;
    assign half_done = busy && (div_cnt == DIV_LAST);

    // ------------------------------------------------------------
    // clock divider and bit timing
    // ------------------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= '0;
            sclk_q     <= 1'b1;
            mosi_q     <= `AD7124_SDO_IDLE;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (accept) begin
                // mode 3, first falling edge puts out the msb
                busy     <= 1'b1;
                div_cnt  <= '0;
                half_cnt <= '0;
                sclk_q   <= 1'b0;
                mosi_q   <= xfer.tx_byte[7];
            end else if (half_done) begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 4'd1;
                if (!half_cnt[0]) begin
                    sclk_q <= 1'b1;
                end else if (half_cnt == 4'd15) begin
                    // last high phase over, sclk already idles high
                    busy       <= 1'b0;
                    rx_valid_q <= 1'b1;
                    mosi_q     <= `AD7124_SDO_IDLE;
                end else begin
                    sclk_q <= 1'b0;
                    mosi_q <= tx_sh[7];
                end
            end else if (busy) begin
                div_cnt <= div_cnt + 5'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // shift registers
    // ------------------------------------------------------------

    always_ff @(posedge spi_clk_i) begin
        if (accept) begin
            tx_sh <= {xfer.tx_byte[6:0], 1'b0};
        end else if (half_done && half_cnt[0]) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        // miso sampled on rising sclk
        if (half_done && !half_cnt[0]) begin
            rx_sh <= {rx_sh[6:0], miso_i};
        end
    end

    assign xfer.xfer_ready = !busy;
    assign xfer.rx_valid   = rx_valid_q;
    assign xfer.rx_byte    = rx_sh;

    assign sclk_o = sclk_q;
    assign mosi_o = mosi_q;

    // no byte may start with sclk parked low
    a_sclk_idle_high : assert property (
        @(posedge spi_clk_i) disable iff (!rst_n_i)
        xfer.xfer_ready |-> sclk_o
    );

endmodule

`default_nettype wire

// File: verilog/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ad7124_consts.svh"

module sample_fifo (
    input  wire logic                 spi_clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 push_valid_i,
    output logic                      push_ready_o,
    input  wire ad7124_pkg::sample_t  push_data_i,
    output logic                      data_valid_o,
    input  wire logic                 data_ready_i,
    output ad7124_pkg::sample_t       data_o
);

    import ad7124_pkg::*;

    localparam int ADDR_W = $clog2(`AD7124_FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`AD7124_FIFO_DEPTH);

    sample_t           mem [`AD7124_FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign push_ready_o = (count != DEPTH_C);
    assign data_valid_o = (count != '0);

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = data_valid_o && data_ready_i;

    // ------------------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge spi_clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // first word fall through, head entry shown directly
    assign data_o = mem[rd_ptr];

    a_count_bound : assert property (
        @(posedge spi_clk_i) disable iff (!rst_n_i)
        count <= DEPTH_C
    );

endmodule

`default_nettype wire

// File: verilog/ad7124_channel.sv
`timescale 1ns/1ps
`default_nettype none

module ad7124_channel (
    input  wire logic                spi_clk_i,
    input  wire logic                rst_n_i,
    // sample stream
    output logic                     data_valid_o,
    input  wire logic                data_ready_i,
    output ad7124_pkg::sample_t      data_o,
    // spi pins
    output logic                     sclk_o,
    output logic                     mosi_o,
    output logic                     cs_n_o,
    input  wire logic                miso_i
);

    import ad7124_pkg::*;

    logic    trigger;
    logic    seq_active;

    // sequencer to fifo
    logic    push_valid;
    logic    push_ready;
    sample_t push_data;

    spi_xfer_if xfer_if ();

    // single adc, chip select held low so dout/rdy stays visible
    assign cs_n_o = 1'b0;

    drdy_trigger i_drdy_trigger (
        .spi_clk_i    (spi_clk_i ),
        .rst_n_i      (rst_n_i   ),
        .miso_i       (miso_i    ),
        .seq_active_i (seq_active),
        .trigger_o    (trigger   )
    );

    conv_sequencer i_conv_sequencer (
        .spi_clk_i    (spi_clk_i ),
        .rst_n_i      (rst_n_i   ),
        .trigger_i    (trigger   ),
        .seq_active_o (seq_active),
        .xfer         (xfer_if   ),
        .push_valid_o (push_valid),
        .push_ready_i (push_ready),
        .push_data_o  (push_data )
    );

    spi_byte_engine i_spi_byte_engine (
        .spi_clk_i (spi_clk_i),
        .rst_n_i   (rst_n_i  ),
        .xfer      (xfer_if  ),
        .sclk_o    (sclk_o   ),
        .mosi_o    (mosi_o   ),
        .miso_i    (miso_i   )
    );

    sample_fifo i_sample_fifo (
        .spi_clk_i    (spi_clk_i   ),
        .rst_n_i      (rst_n_i     ),
        .push_valid_i (push_valid  ),
        .push_ready_o (push_ready  ),
        .push_data_i  (push_data   ),
        .data_valid_o (data_valid_o),
        .data_ready_i (data_ready_i),
        .data_o       (data_o      )
    );

endmodule

`default_nettype wire

// File: tb/tb_ad7124_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ad7124_channel;

    import ad7124_pkg::*;

    localparam logic [7:0] CMD_BYTE   = 8'h42;
    localparam int         HALF_CYC   = 25;
    // eight fifo entries plus the sample held in the sequencer
    localparam int         HOLD_MAX   = 9;
    localparam int         LOST_WAIT  = 2000;
    localparam int         ROWS       = 12;

    logic    spi_clk;
    logic    rst_n;
    logic    data_ready;
    logic    miso;
    logic    data_valid;
    sample_t data;
    logic    sclk;
    logic    mosi;
    logic    cs_n;

    // stimulus table: sample, idle gap, data_ready held low
    sample_t     tbl_sample [ROWS];
    bit          tbl_hold   [ROWS];
    int          tbl_gap    [ROWS];

    sample_t     exp_q [$];
    logic [31:0] rng_state;
    logic        stall_q;
    sample_t     stall_data;

    ad7124_channel uut (
        .spi_clk_i    (spi_clk   ),
        .rst_n_i      (rst_n     ),
        .data_valid_o (data_valid),
        .data_ready_i (data_ready),
        .data_o       (data      ),
        .sclk_o       (sclk      ),
        .mosi_o       (mosi      ),
        .cs_n_o       (cs_n      ),
        .miso_i       (miso      )
    );

    initial begin
        spi_clk = 1'b0;
        forever #2 spi_clk = ~spi_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // output stream monitor
    // ------------------------------------------------------------

    // sampled at the rising edge, before the DUT updates
    always @(posedge spi_clk) begin
        if (!rst_n) begin
            stall_q    <= 1'b0;
            stall_data <= '0;
        end else begin
            if (stall_q) begin
                check_value("data_valid_o", data_valid, 1);
                check_value("data_o held", data, stall_data);
            end
            if (data_valid && data_ready) begin
                assert (exp_q.size() > 0) else begin
                    stop_run("a sample left data_o that was never read from the ADC");
                end
                check_value("data_o", data, exp_q.pop_front());
            end
            stall_q    <= data_valid && !data_ready;
            stall_data <= data;
        end
    end

    // ------------------------------------------------------------
    // ADC model
    // ------------------------------------------------------------

    // signals ready on dout/rdy, then serves one read if sclk arrives
    task automatic adc_convert(input sample_t smp, output bit got_read);
        int          cyc;
        int          falls;
        int          rises;
        int          phase;
        logic        sclk_q;
        logic [31:0] mosi_word;
        got_read  = 1'b0;
        falls     = 0;
        rises     = 0;
        phase     = 0;
        sclk_q    = 1'b1;
        mosi_word = '0;
        @(negedge spi_clk);
        miso = 1'b0;
        cyc  = 0;
        while (sclk && cyc < LOST_WAIT) begin
            @(negedge spi_clk);
            cyc++;
        end
        if (sclk) begin
            // nobody came for this conversion
            miso = 1'b1;
            return;
        end
        got_read = 1'b1;
        cyc      = 0;
        while (rises < 32) begin
            if (cyc > LOST_WAIT) begin
                stop_run("timeout, SCLK stopped in the middle of a read");
            end
            if (sclk !== sclk_q) begin
                if (!sclk) begin
                    // data bits follow the command byte
                    if (falls >= 8) begin
                        miso = smp[31 - falls];
                    end
                    // high phase between bytes is longer
                    if (rises > 0 && rises % 8 != 0) begin
                        check_value("sclk_o high phase", phase, HALF_CYC);
                    end
                    falls++;
                end else begin
                    mosi_word = {mosi_word[30:0], mosi};
                    check_value("sclk_o low phase", phase, HALF_CYC);
                    rises++;
                end
                sclk_q = sclk;
                phase  = 0;
                cyc    = 0;
            end
            @(negedge spi_clk);
            phase++;
            cyc++;
        end
        miso = 1'b1;
        check_value("mosi_o command byte", mosi_word[31:24], CMD_BYTE);
        check_value("mosi_o dummy bytes", mosi_word[23:0], 0);
    endtask

    task automatic wait_drained();
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0 || data_valid) begin
            if (cyc == 5000) begin
                stop_run("timeout, samples did not drain from data_o");
            end
            @(negedge spi_clk);
            cyc++;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        bit got_read;
        bit exp_read;
        rst_n      = 1'b0;
        data_ready = 1'b1;
        miso       = 1'b1;
        rng_state  = 32'hcaf62e7d;
        tbl_sample = '{24'h123456, 24'h800000, 24'h7fffff, 24'h000001,
                       24'ha5a5a5, 24'h5a5a5a, 24'hfedcba, 24'h0f0f0f,
                       24'hc3c3c3, 24'h3c3c3c, 24'h010203, 24'hffffff};
        tbl_hold   = '{0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1};
        for (int i = 0; i < ROWS; i++) begin
            rng_state  = xorshift32(rng_state);
            tbl_gap[i] = 100 + int'(rng_state % 201);
        end
        repeat (3) @(negedge spi_clk);
        rst_n = 1'b1;
        @(negedge spi_clk);
        check_value("data_valid_o", data_valid, 0);
        check_value("sclk_o", sclk, 1);
        check_value("mosi_o", mosi, 1);
        check_value("cs_n_o", cs_n, 0);
        for (int i = 0; i < ROWS; i++) begin
            if (data_ready) begin
                wait_drained();
            end
            data_ready = !tbl_hold[i];
            repeat (tbl_gap[i]) @(negedge spi_clk);
            exp_read = (exp_q.size() < HOLD_MAX);
            adc_convert(tbl_sample[i], got_read);
            if (exp_read) begin
                assert (got_read) else begin
                    stop_run("no SCLK activity for a conversion that should be read");
                end
            end else begin
                assert (!got_read) else begin
                    stop_run("SCLK activity for a conversion that should be lost");
                end
            end
            if (got_read) begin
                exp_q.push_back(tbl_sample[i]);
            end
        end
        data_ready = 1'b1;
        wait_drained();
        repeat (20) @(negedge spi_clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/ad7124_pkg.sv
common/spi_xfer_if.sv
verilog/drdy_trigger.sv
verilog/conv_sequencer.sv
spi_exec/spi_byte_engine.sv
verilog/sample_fifo.sv
verilog/ad7124_channel.sv
tb/tb_ad7124_channel.sv

// File: Makefile
TOP = tb_ad7124_channel

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Errors found" sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
